// ==== common/fp32_pkg.sv ====
package fp32_pkg;

    // IEEE 754 single precision field widths
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int MANT_W = 24;     // fraction plus hidden bit
    localparam int PROD_W = 48;     // full mantissa product

    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 255;  // infinity or NaN

    // quiet NaN payload driven on every NaN result
    localparam logic [FRAC_W-1:0] NAN_FRAC = '1;

    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exp;
        logic [FRAC_W-1:0] frac;
    } fp32_fields_t;

    // words move between blocks as raw bits and are decoded where used
    typedef union packed {
        logic [31:0]  bits;
        fp32_fields_t f;
    } fp32_t;

endpackage

// ==== src/leading_one_detector.sv ====
`timescale 1ns/1ps

module leading_one_detector #(
    parameter int WIDTH = 48
) (
    input  logic [WIDTH-1:0]         vec,
    output logic [$clog2(WIDTH)-1:0] pos,
    output logic                     found
);

    localparam int POS_W = $clog2(WIDTH);

    // priority scan from the top bit down, first hit wins
    always_comb begin
        pos   = '0;
        found = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (vec[i] && !found) begin
                pos   = POS_W'(i);
                found = 1'b1;
            end
        end
    end

endmodule

// ==== multiplier/fp32_mul_normalize.sv ====
`timescale 1ns/1ps

module fp32_mul_normalize (
    input  fp32_pkg::fp32_t             a,
    input  fp32_pkg::fp32_t             b,
    output logic                        sign,
    output logic [fp32_pkg::PROD_W-1:0] norm_man,
    output logic signed [9:0]           norm_exp,
    output logic                        nan,
    output logic                        zero
);

    import fp32_pkg::*;

    localparam int POS_W = $clog2(PROD_W);
    localparam int LEAD  = PROD_W - 2;      // hidden bit position after alignment

    logic [MANT_W-1:0]  a_man;
    logic [MANT_W-1:0]  b_man;
    logic               a_flush;
    logic               b_flush;
    logic               a_nan;
    logic               b_nan;
    logic [PROD_W-1:0]  prod;
    logic [POS_W-1:0]   lead_pos;
    logic               lead_found;
    logic signed [9:0]  exp_sum;

    assign sign = a.f.sign ^ b.f.sign;

    // exponent 0 covers zero and subnormals alike
    assign a_flush = (a.f.exp == '0);
    assign b_flush = (b.f.exp == '0);

    assign a_man = a_flush ? '0 : {1'b1, a.f.frac};   // hidden one restored
    assign b_man = b_flush ? '0 : {1'b1, b.f.frac};

    assign a_nan = (a.f.exp == EXP_W'(EXP_MAX)) && (a.f.frac != '0);
    assign b_nan = (b.f.exp == EXP_W'(EXP_MAX)) && (b.f.frac != '0);
    assign nan   = a_nan | b_nan;

    // 24x24 unsigned product worth prod / 2^46
    assign prod = a_man * b_man;

    leading_one_detector #(
        .WIDTH(PROD_W)
    ) u_lod (
        .vec  (prod),
        .pos  (lead_pos),
        .found(lead_found)
    );

    // a flushed operand gives an all-zero product
    assign zero = ~lead_found;

    // biased exponent assuming the leading one sits at bit 46
    assign exp_sum = $signed({2'b00, a.f.exp})
                   + $signed({2'b00, b.f.exp})
                   - 10'(EXP_BIAS);

    always_comb begin
        if (lead_pos == POS_W'(LEAD + 1)) begin
            // product in [2,4) so move down one and keep bit 0 as sticky
            norm_man = {1'b0, prod[PROD_W-1:1]} | {{(PROD_W-1){1'b0}}, prod[0]};
            norm_exp = exp_sum + 10'sd1;
        end else begin
            norm_man = prod;                        // leading one already at bit 46
            norm_exp = exp_sum;
        end
    end

endmodule

// ==== multiplier/fp32_mul_round.sv ====
`timescale 1ns/1ps

module fp32_mul_round (
    input  logic                        sign,
    input  logic [fp32_pkg::PROD_W-1:0] norm_man,
    input  logic signed [9:0]           norm_exp,
    input  logic                        nan,
    input  logic                        zero,
    output fp32_pkg::fp32_t             product
);

    import fp32_pkg::*;

    localparam int FRAC_LSB = PROD_W - 2 - FRAC_W;  // bit 23 of the aligned product

    logic [FRAC_W-1:0]  frac_trunc;
    logic               guard;
    logic               round_bit;
    logic               sticky;
    logic               round_up;
    logic [FRAC_W:0]    frac_sum;   // top bit catches the carry-out
    logic [FRAC_W-1:0]  frac_rnd;
    logic signed [9:0]  exp_rnd;

    assign frac_trunc = norm_man[FRAC_LSB +: FRAC_W];
    assign guard      = norm_man[FRAC_LSB-1];
    assign round_bit  = norm_man[FRAC_LSB-2];
    assign sticky     = |norm_man[FRAC_LSB-3:0];

    // nearest even, an exact tie rounds up only from an odd lsb
    assign round_up = guard & (round_bit | sticky | frac_trunc[0]);

    assign frac_sum = {1'b0, frac_trunc} + {{FRAC_W{1'b0}}, round_up};

    // all-ones fraction plus one wraps to zero with the exponent bumped
    assign frac_rnd = frac_sum[FRAC_W-1:0];
    assign exp_rnd  = norm_exp + $signed({9'd0, frac_sum[FRAC_W]});

    always_comb begin
        product.bits = '0;
        if (nan) begin
            product.f.sign = sign;
            product.f.exp  = EXP_W'(EXP_MAX);
            product.f.frac = NAN_FRAC;
        end else if (exp_rnd > 10'(EXP_MAX - 1)) begin
            product.f.sign = sign;                  // signed infinity
            product.f.exp  = EXP_W'(EXP_MAX);
        end else if (exp_rnd < 10'sd1 || zero) begin
            product.bits = '0;                      // underflow flushes to +0
        end else begin
            product.f.sign = sign;
            product.f.exp  = exp_rnd[EXP_W-1:0];
            product.f.frac = frac_rnd;
        end
    end

endmodule

// ==== adder/fp32_add.sv ====
`timescale 1ns/1ps

module fp32_add (
    input  fp32_pkg::fp32_t x,
    input  fp32_pkg::fp32_t y,
    output fp32_pkg::fp32_t sum
);

    import fp32_pkg::*;

    localparam int SUM_W = MANT_W + 1;       // room for the add carry
    localparam int POS_W = $clog2(SUM_W);

    logic               x_special;
    logic               y_special;
    logic [MANT_W-1:0]  x_man;
    logic [MANT_W-1:0]  y_man;
    logic               x_big;
    logic               big_sign;
    logic [EXP_W-1:0]   big_exp;
    logic [EXP_W-1:0]   small_exp;
    logic [MANT_W-1:0]  big_man;
    logic [MANT_W-1:0]  small_man;
    logic [EXP_W-1:0]   shift;
    logic [MANT_W-1:0]  small_aligned;
    logic               eff_sub;
    logic [SUM_W-1:0]   raw;
    logic [POS_W-1:0]   lead_pos;
    logic               lead_found;
    logic [SUM_W-1:0]   aligned;
    logic signed [9:0]  res_exp;

    assign x_special = (x.f.exp == EXP_W'(EXP_MAX));
    assign y_special = (y.f.exp == EXP_W'(EXP_MAX));

    // subnormals flush to a zero mantissa
    assign x_man = (x.f.exp == '0) ? '0 : {1'b1, x.f.frac};
    assign y_man = (y.f.exp == '0) ? '0 : {1'b1, y.f.frac};

    // larger magnitude first, by exponent then mantissa
    assign x_big = (x.f.exp > y.f.exp) || ((x.f.exp == y.f.exp) && (x_man >= y_man));

    always_comb begin
        if (x_big) begin
            big_sign  = x.f.sign;
            big_exp   = x.f.exp;
            big_man   = x_man;
            small_exp = y.f.exp;
            small_man = y_man;
        end else begin
            big_sign  = y.f.sign;
            big_exp   = y.f.exp;
            big_man   = y_man;
            small_exp = x.f.exp;
            small_man = x_man;
        end
    end

    assign shift         = big_exp - small_exp;
    assign small_aligned = small_man >> shift;      // shifted-out bits are dropped

    assign eff_sub = x.f.sign ^ y.f.sign;

    // big >= small so the difference never goes negative
    assign raw = eff_sub ? ({1'b0, big_man} - {1'b0, small_aligned})
                         : ({1'b0, big_man} + {1'b0, small_aligned});

    leading_one_detector #(
        .WIDTH(SUM_W)
    ) u_lod (
        .vec  (raw),
        .pos  (lead_pos),
        .found(lead_found)
    );

    // leading one lands on bit 24 and the fraction is read from 23:1
    assign aligned = raw << (POS_W'(MANT_W) - lead_pos);

    // bit 23 is the unshifted hidden position
    assign res_exp = $signed({2'b00, big_exp})
                   + $signed(10'(lead_pos))
                   - 10'(FRAC_W);

    always_comb begin
        sum.bits = '0;
        if (x_special) begin
            sum = x;                                // inf or NaN product wins
        end else if (y_special) begin
            sum = y;
        end else if (!lead_found || res_exp < 10'sd1) begin
            sum.bits = '0;                          // cancellation or underflow
        end else if (res_exp >= 10'(EXP_MAX)) begin
            sum.f.sign = big_sign;
            sum.f.exp  = EXP_W'(EXP_MAX);
        end else begin
            sum.f.sign = big_sign;
            sum.f.exp  = res_exp[EXP_W-1:0];
            sum.f.frac = aligned[MANT_W-1:1];
        end
    end

endmodule

// ==== src/fp32_mac.sv ====
`timescale 1ns/1ps

module fp32_mac (
    input  logic            clk,
    input  logic            reset,
    input  logic            in_valid,
    input  fp32_pkg::fp32_t a,
    input  fp32_pkg::fp32_t b,
    input  fp32_pkg::fp32_t acc,
    output logic            out_valid,
    output fp32_pkg::fp32_t result
);

    import fp32_pkg::*;

    logic               mul_sign;
    logic [PROD_W-1:0]  norm_man;
    logic signed [9:0]  norm_exp;
    logic               mul_nan;
    logic               mul_zero;
    fp32_t              product;

    fp32_t              prod_s1;
    fp32_t              acc_s1;
    logic               valid_s1;
    fp32_t              sum;

    fp32_mul_normalize u_mul_norm (
        .a       (a),
        .b       (b),
        .sign    (mul_sign),
        .norm_man(norm_man),
        .norm_exp(norm_exp),
        .nan     (mul_nan),
        .zero    (mul_zero)
    );

    fp32_mul_round u_mul_round (
        .sign    (mul_sign),
        .norm_man(norm_man),
        .norm_exp(norm_exp),
        .nan     (mul_nan),
        .zero    (mul_zero),
        .product (product)
    );

    // stage 1 data, acc delayed to line up with the product
    always_ff @(posedge clk) begin
        if (in_valid) begin
            prod_s1 <= product;
            acc_s1  <= acc;
        end
    end

    fp32_add u_add (
        .x  (prod_s1),
        .y  (acc_s1),
        .sum(sum)
    );

    // stage 2 data
    always_ff @(posedge clk) begin
        if (valid_s1) begin
            result <= sum;
        end
    end

    // valid strobe follows the data two edges behind in_valid
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_s1  <= in_valid;
            out_valid <= valid_s1;
        end
    end

endmodule

// ==== dv/fp32_mac_chk.sv ====
`timescale 1ns/1ps

module fp32_mac_chk (
    input logic            clk,
    input logic            reset,
    input logic            in_valid,
    input fp32_pkg::fp32_t a,
    input fp32_pkg::fp32_t b,
    input logic            out_valid,
    input fp32_pkg::fp32_t result
);

    import fp32_pkg::*;

    function automatic logic is_nan(input fp32_t w);
        return (w.f.exp == EXP_W'(EXP_MAX)) && (w.f.frac != '0);
    endfunction

    // two register stages between the strobes once reset is gone
    strobe_latency: assert property (@(posedge clk)
        !$past(reset) && !$past(reset, 2) |-> out_valid == $past(in_valid, 2))
    else $error("out_valid does not follow in_valid by two cycles");

    strobe_in_reset: assert property (@(posedge clk)
        $past(reset) |-> !out_valid)
    else $error("out_valid is high while reset is held");

    // NaN wins over whatever the accumulator holds
    nan_propagates: assert property (@(posedge clk) disable iff (reset)
        in_valid && (is_nan(a) || is_nan(b)) |-> ##2 is_nan(result))
    else $error("a NaN operand did not give a NaN result");

endmodule

bind fp32_mac fp32_mac_chk u_chk (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .a        (a),
    .b        (b),
    .out_valid(out_valid),
    .result   (result)
);

// ==== dv/fp32_mac_tb.sv ====
`timescale 1ns/1ps

module fp32_mac_tb;

    import fp32_pkg::*;

    localparam int TIMEOUT_CYCLES = 100;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] acc;
    logic        out_valid;
    logic [31:0] result;

    logic [31:0] exp_q[$];     // expected words in issue order
    logic [31:0] head_word;    // oldest word still waiting
    int          pending;
    logic        drained;

    fp32_mac uut (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .acc      (acc),
        .out_valid(out_valid),
        .result   (result)
    );

    always #2 clk = ~clk;

    // exact for magnitudes below 2^24
    function automatic logic [31:0] int_to_float(input int value);
        logic              s;
        int                mag;
        int                msb;
        int                i;
        logic [FRAC_W-1:0] frac;
        s   = (value < 0);
        mag = s ? -value : value;
        msb = 0;
        if (mag == 0) begin
            return 32'h0;
        end
        for (i = 0; i < MANT_W; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        frac = FRAC_W'(mag << (FRAC_W - msb));     // hidden one falls off the top
        return {s, EXP_W'(EXP_BIAS + msb), frac};
    endfunction

    function automatic int signed_rand(input int max);
        int mag;
        mag = int'($urandom_range(1, max));
        return ($urandom_range(0, 1) == 1) ? -mag : mag;
    endfunction

    task automatic send(input logic [31:0] op_a, input logic [31:0] op_b,
                        input logic [31:0] op_acc, input logic [31:0] expected);
        @(posedge clk);
        in_valid <= 1'b1;
        a        <= op_a;
        b        <= op_b;
        acc      <= op_acc;
        exp_q.push_back(expected);
    endtask

    // mostly back to back strobes with a short idle stretch now and then
    task automatic insert_gap();
        int n;
        n = ($urandom_range(0, 3) == 0) ? int'($urandom_range(1, 3)) : 0;
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic int_product_ops(input int count);
        int x;
        int y;
        repeat (count) begin
            x = signed_rand(255);
            y = signed_rand(255);
            send(int_to_float(x), int_to_float(y), 32'h0, int_to_float(x * y));
            insert_gap();
        end
    endtask

    task automatic int_mac_ops(input int count);
        int x;
        int y;
        int z;
        repeat (count) begin
            x = signed_rand(2047);
            y = signed_rand(2047);
            if ($urandom_range(0, 3) == 0) begin
                z = -(x * y);                       // exact cancellation
            end else begin
                z = signed_rand(8388607);
            end
            send(int_to_float(x), int_to_float(y), int_to_float(z), int_to_float(x * y + z));
            insert_gap();
        end
    endtask

    task automatic rounding_ops(input int count);
        int          k;
        logic [31:0] w;
        repeat (count) begin
            k = int'($urandom_range(0, 2047));
            w = {1'b0, EXP_W'(EXP_BIAS), FRAC_W'(k)};
            // k^2 term stays below half an ulp
            send(w, w, 32'h0, {1'b0, EXP_W'(EXP_BIAS), FRAC_W'(2 * k)});
            insert_gap();
        end
        send(32'h3F800800, 32'h3F800800, 32'h0, 32'h3F801000);    // tie rounds down to even
        send(32'h3F800001, 32'h3FC00000, 32'h0, 32'h3FC00002);    // tie rounds up to even
    endtask

    task automatic special_value_ops(input int count);
        logic [31:0] nan_word;
        logic [31:0] other;
        logic [31:0] inf_word;
        logic        s;
        logic        t;
        repeat (count) begin
            nan_word = {1'($urandom_range(0, 1)), EXP_W'(EXP_MAX),
                        FRAC_W'($urandom_range(1, 32'h7FFFFF))};
            other    = $urandom();
            send(nan_word, other, $urandom(),
                 {nan_word[31] ^ other[31], EXP_W'(EXP_MAX), NAN_FRAC});
            send(other, nan_word, $urandom(),
                 {nan_word[31] ^ other[31], EXP_W'(EXP_MAX), NAN_FRAC});
            s = 1'($urandom_range(0, 1));
            t = 1'($urandom_range(0, 1));
            // 2^100 squared is far past the top exponent
            send({s, EXP_W'(EXP_BIAS + 100), 23'h0}, {t, EXP_W'(EXP_BIAS + 100), 23'h0},
                 int_to_float(signed_rand(1000)), {s ^ t, EXP_W'(EXP_MAX), 23'h0});
            inf_word = {s, EXP_W'(EXP_MAX), 23'h0};
            send(int_to_float(signed_rand(255)), int_to_float(signed_rand(255)),
                 inf_word, inf_word);
            insert_gap();
        end
    endtask

    task automatic wait_for_drain(output logic empty);
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        empty = (exp_q.size() == 0);
    endtask

    // one pop per result while the assertion reads the head one edge later
    always @(posedge clk) begin
        if (out_valid && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
        pending   <= exp_q.size();
        head_word <= (exp_q.size() > 0) ? exp_q[0] : 32'h0;
    end

    check_result: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> result == head_word)
    else begin
        $display("Fail result got %h expected %h", $sampled(result), $sampled(head_word));
        $display("TESTS FAILED");
        $fatal(1);
    end

    check_pending: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> pending > 0)
    else begin
        $display("a result came out with no operation outstanding");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        clk      = 1'b0;
        reset    = 1'b1;
        in_valid = 1'b0;
        a        = 32'h0;
        b        = 32'h0;
        acc      = 32'h0;
        void'($urandom(32'hd379d4d9));
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        int_product_ops(40);
        int_mac_ops(60);
        rounding_ops(30);
        special_value_ops(10);
        @(posedge clk);
        in_valid <= 1'b0;
        wait_for_drain(drained);
        repeat (2) @(posedge clk);                 // let the last checks fire
        if (drained) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("timed out with %0d results still missing", exp_q.size());
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

endmodule

// ==== src.f ====
common/fp32_pkg.sv
src/leading_one_detector.sv
multiplier/fp32_mul_normalize.sv
multiplier/fp32_mul_round.sv
adder/fp32_add.sv
src/fp32_mac.sv
dv/fp32_mac_chk.sv
dv/fp32_mac_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the fp32 MAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module fp32_mac_tb -f src.f -o fp32_mac_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fp32_mac_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit $status
fi

exit 0
